// File: rtl/streamer_pkg.sv
// Widths, bus structs and enums shared by the streamer RTL and its testbench
package streamer_pkg;

  localparam int unsigned DATA_W   = 32;
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned LEN_W    = 8;
  localparam int unsigned NUM_CHAN = 3;

  // Memory channel index, also the mux port number
  typedef enum logic [1:0] {
    CHAN_X = 2'd0,
    CHAN_W = 2'd1,
    CHAN_Z = 2'd2
  } chan_id_e;

  typedef enum logic {
    GEN_IDLE = 1'b0,
    GEN_RUN  = 1'b1
  } gen_state_e;

  // Per-stream control, start is a single-cycle pulse
  typedef struct packed {
    logic              start;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [LEN_W-1:0]  len;
  } stream_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } stream_beat_t;

  // Word-addressed memory request, wen high for a write
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } mem_rsp_t;

  typedef struct packed {
    logic x_done;
    logic w_done;
    logic z_done;
  } streamer_flags_t;

endpackage

// File: rtl/streamer_addr_gen.sv
// Strided word address generator, stepped once per accepted memory request
module streamer_addr_gen
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  stream_ctrl_t      ctrl_i,
  input  logic              step_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              active_o,
  output logic              last_o
);

  gen_state_e        state_q;
  logic [LEN_W-1:0]  remain_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic              advance;

  // Steps outside a run are ignored
  assign advance = step_i && (state_q == GEN_RUN);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= GEN_IDLE;
      remain_q <= '0;
    end else if (clear_i) begin
      state_q  <= GEN_IDLE;
      remain_q <= '0;
    end else if (ctrl_i.start) begin
      // Zero length means nothing to issue
      state_q  <= (ctrl_i.len != '0) ? GEN_RUN : GEN_IDLE;
      remain_q <= ctrl_i.len;
    end else if (advance) begin
      remain_q <= remain_q - LEN_W'(1);
      if (last_o) begin
        state_q <= GEN_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.start) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
    end else if (advance) begin
      // Wraps modulo the address space
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr_o   = addr_q;
  assign active_o = (state_q == GEN_RUN);
  assign last_o   = active_o && (remain_q == LEN_W'(1));

endmodule

// File: rtl/streamer_source.sv
// Load channel, turns strided reads into an outgoing stream through a credit-checked FIFO
module streamer_source
  import streamer_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
)(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         clear_i,
  input  stream_ctrl_t ctrl_i,
  output mem_req_t     mem_req_o,
  input  logic         mem_gnt_i,
  input  mem_rsp_t     mem_rsp_i,
  output stream_beat_t stream_o,
  input  logic         ready_i,
  output logic         done_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  logic [DATA_W-1:0] fifo_q [FIFO_DEPTH];
  logic [CNT_W-1:0]  wr_ptr_q;
  logic [CNT_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  pending_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_cnt_q;
  logic              done_q;
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_active;
  logic              grant;
  logic              push;
  logic              pop;
  logic              empty;

  streamer_addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .clear_i  ( clear_i    ),
    .ctrl_i   ( ctrl_i     ),
    .step_i   ( grant      ),
    .addr_o   ( gen_addr   ),
    .active_o ( gen_active ),
    .last_o   (            )
  );

  // pending_q counts reads in flight plus words held, a read needs a free slot
  assign mem_req_o.req   = gen_active && (pending_q < CNT_W'(FIFO_DEPTH));
  assign mem_req_o.wen   = 1'b0;
  assign mem_req_o.addr  = gen_addr;
  assign mem_req_o.wdata = '0;

  assign grant = mem_req_o.req && mem_gnt_i;
  assign push  = mem_rsp_i.r_valid;
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign pop   = !empty && ready_i;

  assign stream_o.valid = !empty;
  assign stream_o.data  = fifo_q[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      pending_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      pending_q <= '0;
    end else begin
      wr_ptr_q  <= wr_ptr_q + CNT_W'(push);
      rd_ptr_q  <= rd_ptr_q + CNT_W'(pop);
      pending_q <= pending_q + CNT_W'(grant) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q[PTR_W-1:0]] <= mem_rsp_i.r_data;
    end
  end

  // Beat counter against the latched length drives the done flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      len_q      <= '0;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (clear_i) begin
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (ctrl_i.start) begin
      len_q      <= ctrl_i.len;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (pop) begin
      beat_cnt_q <= beat_cnt_q + LEN_W'(1);
      if (beat_cnt_q == len_q - LEN_W'(1)) begin
        done_q <= 1'b1;
      end
    end
  end

  assign done_o = done_q;

endmodule

// File: rtl/streamer_sink.sv
// Store channel, writes each incoming Z beat to the next strided address
module streamer_sink
  import streamer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         clear_i,
  input  stream_ctrl_t ctrl_i,
  input  stream_beat_t stream_i,
  output logic         ready_o,
  output mem_req_t     mem_req_o,
  input  logic         mem_gnt_i,
  output logic         done_o
);

  logic [ADDR_W-1:0] gen_addr;
  logic              gen_active;
  logic              gen_last;
  logic              grant;
  logic              done_q;

  streamer_addr_gen i_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .clear_i  ( clear_i    ),
    .ctrl_i   ( ctrl_i     ),
    .step_i   ( grant      ),
    .addr_o   ( gen_addr   ),
    .active_o ( gen_active ),
    .last_o   ( gen_last   )
  );

  assign mem_req_o.req   = gen_active && stream_i.valid;
  assign mem_req_o.wen   = 1'b1;
  assign mem_req_o.addr  = gen_addr;
  assign mem_req_o.wdata = stream_i.data;

  // A grant consumes the beat and advances the address together
  assign grant   = mem_req_o.req && mem_gnt_i;
  assign ready_o = grant;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (clear_i || ctrl_i.start) begin
      done_q <= 1'b0;
    end else if (grant && gen_last) begin
      done_q <= 1'b1;
    end
  end

  assign done_o = done_q;

endmodule

// File: rtl/streamer_tcdm_mux.sv
// Round-robin arbiter sharing one memory port among the load and store channels
module streamer_tcdm_mux
  import streamer_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         clear_i,
  input  mem_req_t [NUM_CHAN-1:0]      chan_req_i,
  output logic     [NUM_CHAN-1:0]      chan_gnt_o,
  output mem_rsp_t [NUM_CHAN-1:0]      chan_rsp_o,
  output mem_req_t                     mem_req_o,
  input  logic                         mem_gnt_i,
  input  mem_rsp_t                     mem_rsp_i
);

  chan_id_e last_q;
  chan_id_e sel;
  chan_id_e rd_chan_q;
  logic     rd_pend_q;
  logic     any_req;
  logic     mem_grant;

  // Search downwards so the channel right after the last winner ends up selected
  always_comb begin
    int cand;
    sel     = last_q;
    any_req = 1'b0;
    for (int k = NUM_CHAN; k >= 1; k--) begin
      cand = (int'(last_q) + k) % NUM_CHAN;
      if (chan_req_i[cand].req) begin
        sel     = chan_id_e'(2'(cand));
        any_req = 1'b1;
      end
    end
  end

  assign mem_req_o = any_req ? chan_req_i[sel] : '0;
  assign mem_grant = any_req && mem_gnt_i;

  always_comb begin
    chan_gnt_o      = '0;
    chan_gnt_o[sel] = mem_grant;
  end

  // Read data goes back only to the channel that issued it
  always_comb begin
    for (int i = 0; i < NUM_CHAN; i++) begin
      chan_rsp_o[i].r_valid = mem_rsp_i.r_valid && rd_pend_q && (int'(rd_chan_q) == i);
      chan_rsp_o[i].r_data  = mem_rsp_i.r_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q    <= CHAN_Z;
      rd_chan_q <= CHAN_X;
      rd_pend_q <= 1'b0;
    end else if (clear_i) begin
      last_q    <= CHAN_Z;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_grant && !mem_req_o.wen;
      if (mem_grant) begin
        last_q    <= sel;
        rd_chan_q <= sel;
      end
    end
  end

endmodule

// File: rtl/streamer_top.sv
// Streamer top level, X and W load sources and the Z sink behind one shared memory port
module streamer_top
  import streamer_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
)(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  stream_ctrl_t    x_ctrl_i,
  input  stream_ctrl_t    w_ctrl_i,
  input  stream_ctrl_t    z_ctrl_i,
  output stream_beat_t    x_stream_o,
  input  logic            x_ready_i,
  output stream_beat_t    w_stream_o,
  input  logic            w_ready_i,
  input  stream_beat_t    z_stream_i,
  output logic            z_ready_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_gnt_i,
  input  mem_rsp_t        mem_rsp_i,
  output streamer_flags_t flags_o
);

  mem_req_t [NUM_CHAN-1:0] chan_req;
  logic     [NUM_CHAN-1:0] chan_gnt;
  mem_rsp_t [NUM_CHAN-1:0] chan_rsp;

  // Output side, operand sources
  streamer_source #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_x_source (
    .clk_i     ( clk_i            ),
    .rst_n_i   ( rst_n_i          ),
    .clear_i   ( clear_i          ),
    .ctrl_i    ( x_ctrl_i         ),
    .mem_req_o ( chan_req[CHAN_X] ),
    .mem_gnt_i ( chan_gnt[CHAN_X] ),
    .mem_rsp_i ( chan_rsp[CHAN_X] ),
    .stream_o  ( x_stream_o       ),
    .ready_i   ( x_ready_i        ),
    .done_o    ( flags_o.x_done   )
  );

  streamer_source #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_w_source (
    .clk_i     ( clk_i            ),
    .rst_n_i   ( rst_n_i          ),
    .clear_i   ( clear_i          ),
    .ctrl_i    ( w_ctrl_i         ),
    .mem_req_o ( chan_req[CHAN_W] ),
    .mem_gnt_i ( chan_gnt[CHAN_W] ),
    .mem_rsp_i ( chan_rsp[CHAN_W] ),
    .stream_o  ( w_stream_o       ),
    .ready_i   ( w_ready_i        ),
    .done_o    ( flags_o.w_done   )
  );

  // Input side, result sink, has no response path
  streamer_sink i_z_sink (
    .clk_i     ( clk_i            ),
    .rst_n_i   ( rst_n_i          ),
    .clear_i   ( clear_i          ),
    .ctrl_i    ( z_ctrl_i         ),
    .stream_i  ( z_stream_i       ),
    .ready_o   ( z_ready_o        ),
    .mem_req_o ( chan_req[CHAN_Z] ),
    .mem_gnt_i ( chan_gnt[CHAN_Z] ),
    .done_o    ( flags_o.z_done   )
  );

  streamer_tcdm_mux i_tcdm_mux (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .clear_i    ( clear_i   ),
    .chan_req_i ( chan_req  ),
    .chan_gnt_o ( chan_gnt  ),
    .chan_rsp_o ( chan_rsp  ),
    .mem_req_o  ( mem_req_o ),
    .mem_gnt_i  ( mem_gnt_i ),
    .mem_rsp_i  ( mem_rsp_i )
  );

endmodule

// File: testbench/tb_streamer_properties.sv
// Protocol assertions on the streamer top-level ports, bound into streamer_top
module tb_streamer_properties
  import streamer_pkg::*;
(
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         clear_i,
  input mem_req_t     mem_req_o,
  input logic         mem_gnt_i,
  input mem_rsp_t     mem_rsp_i,
  input stream_beat_t x_stream_o,
  input logic         x_ready_i,
  input stream_beat_t w_stream_o,
  input logic         w_ready_i,
  input logic         z_ready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions, polled by the testbench
  int unsigned fail_cnt = 0;

  // Read data only in the cycle after a granted read
  rsp_after_read_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.r_valid |-> $past(mem_req_o.req && mem_gnt_i && !mem_req_o.wen))
    else begin
      fail_cnt++;
      $error("read response without a granted read");
    end

  x_valid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    x_stream_o.valid && !x_ready_i |=> x_stream_o.valid && $stable(x_stream_o.data))
    else begin
      fail_cnt++;
      $error("X valid dropped or data changed before ready");
    end

  w_valid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    w_stream_o.valid && !w_ready_i |=> w_stream_o.valid && $stable(w_stream_o.data))
    else begin
      fail_cnt++;
      $error("W valid dropped or data changed before ready");
    end

  // Z is consumed only by a granted write
  z_ready_write_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    z_ready_o |-> mem_req_o.req && mem_gnt_i && mem_req_o.wen)
    else begin
      fail_cnt++;
      $error("Z ready without a granted write");
    end

endmodule

bind streamer_top tb_streamer_properties i_props (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .clear_i    ( clear_i    ),
  .mem_req_o  ( mem_req_o  ),
  .mem_gnt_i  ( mem_gnt_i  ),
  .mem_rsp_i  ( mem_rsp_i  ),
  .x_stream_o ( x_stream_o ),
  .x_ready_i  ( x_ready_i  ),
  .w_stream_o ( w_stream_o ),
  .w_ready_i  ( w_ready_i  ),
  .z_ready_o  ( z_ready_o  )
);

// File: testbench/tb_streamer.sv
// Drives random X, W and Z streams through streamer_top and checks them against a memory model
module tb_streamer
  import streamer_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned MAX_LEN      = 40;
  localparam int unsigned ROUNDS       = 3;

  logic              clk_i;
  logic              rst_n_i;
  logic              clear_i;
  stream_ctrl_t      x_ctrl;
  stream_ctrl_t      w_ctrl;
  stream_ctrl_t      z_ctrl;
  stream_beat_t      x_stream;
  stream_beat_t      w_stream;
  stream_beat_t      z_stream;
  logic              x_ready;
  logic              w_ready;
  logic              z_ready;
  mem_req_t          mem_req;
  logic              mem_gnt;
  mem_rsp_t          mem_rsp;
  streamer_flags_t   flags;

  logic [DATA_W-1:0] mem [2**ADDR_W];
  logic [DATA_W-1:0] x_exp_q [$];
  logic [DATA_W-1:0] w_exp_q [$];
  logic [DATA_W-1:0] z_src_q [$];
  logic [DATA_W-1:0] z_data_q [$];
  logic [ADDR_W-1:0] z_addr_q [$];
  logic [DATA_W-1:0] z_chk_data_q [$];
  logic [ADDR_W-1:0] z_chk_addr_q [$];
  logic [31:0]       lfsr_q;
  logic              rd_pend;
  logic [DATA_W-1:0] rd_data;
  logic              z_took;
  int unsigned       stretch_bits;
  int unsigned       x_hold;
  int unsigned       w_hold;
  int unsigned       cycle_cnt;
  int unsigned       cycle_limit;
  string             test_name;

  streamer_top #(
    .FIFO_DEPTH ( 4 )
  ) i_dut (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .clear_i    ( clear_i  ),
    .x_ctrl_i   ( x_ctrl   ),
    .w_ctrl_i   ( w_ctrl   ),
    .z_ctrl_i   ( z_ctrl   ),
    .x_stream_o ( x_stream ),
    .x_ready_i  ( x_ready  ),
    .w_stream_o ( w_stream ),
    .w_ready_i  ( w_ready  ),
    .z_stream_i ( z_stream ),
    .z_ready_o  ( z_ready  ),
    .mem_req_o  ( mem_req  ),
    .mem_gnt_i  ( mem_gnt  ),
    .mem_rsp_i  ( mem_rsp  ),
    .flags_o    ( flags    )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("Error in %s: %s", test_name, what);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  // Base and stride come from the low bits only, so regions can be kept apart
  function automatic stream_ctrl_t random_ctrl(input int unsigned base_bits,
                                               input int unsigned stride_bits);
    stream_ctrl_t c;
    c.start     = 1'b1;
    c.base      = ADDR_W'(rand_bits(base_bits));
    c.stride    = ADDR_W'(rand_bits(stride_bits));
    c.len       = LEN_W'(1 + rand_bits(6) % MAX_LEN);
    cycle_limit += 64 * c.len;
    return c;
  endfunction

  task automatic queue_reads(input chan_id_e ch, input stream_ctrl_t c);
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < c.len; i++) begin
      a = c.base + ADDR_W'(i * c.stride);
      if (ch == CHAN_X) begin
        x_exp_q.push_back(mem[a]);
      end else begin
        w_exp_q.push_back(mem[a]);
      end
    end
  endtask

  task automatic queue_writes(input stream_ctrl_t c);
    logic [DATA_W-1:0] d;
    z_chk_addr_q.delete();
    z_chk_data_q.delete();
    for (int i = 0; i < c.len; i++) begin
      d = rand_bits(DATA_W);
      z_src_q.push_back(d);
      z_data_q.push_back(d);
      z_chk_data_q.push_back(d);
      z_addr_q.push_back(c.base + ADDR_W'(i * c.stride));
      z_chk_addr_q.push_back(c.base + ADDR_W'(i * c.stride));
    end
  endtask

  // One clock of stimulus applied on the falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    x_ctrl.start    = 1'b0;
    w_ctrl.start    = 1'b0;
    z_ctrl.start    = 1'b0;
    clear_i         = 1'b0;
    mem_rsp.r_valid = rd_pend;
    mem_rsp.r_data  = rd_data;
    mem_gnt         = (rand_bits(2) != 0);
    if (x_hold == 0) begin
      x_ready = (rand_bits(1) != 0);
      x_hold  = rand_bits(stretch_bits);
    end else begin
      x_hold--;
    end
    if (w_hold == 0) begin
      w_ready = (rand_bits(1) != 0);
      w_hold  = rand_bits(stretch_bits);
    end else begin
      w_hold--;
    end
    // Z beat is held until the sink takes it
    if (!z_stream.valid || z_took) begin
      if (z_src_q.size() != 0 && rand_bits(2) != 0) begin
        z_stream.valid = 1'b1;
        z_stream.data  = z_src_q.pop_front();
      end else begin
        z_stream = '0;
      end
    end
  endtask

  task automatic wait_done(input streamer_flags_t need);
    do begin
      next_cycle();
    end while ((flags & need) != need);
  endtask

  task automatic check_idle(input string what);
    assert (!x_stream.valid && !w_stream.valid && !mem_req.req && !z_ready && flags == '0)
      else report_failure({"outputs not idle ", what});
  endtask

  task automatic check_drained();
    assert (x_exp_q.size() == 0) else report_mismatch("x words left", 0, x_exp_q.size());
    assert (w_exp_q.size() == 0) else report_mismatch("w words left", 0, w_exp_q.size());
    assert (z_addr_q.size() == 0) else report_mismatch("z writes left", 0, z_addr_q.size());
    assert (!x_stream.valid && !w_stream.valid)
      else report_failure("a stream is still valid after its done flag");
  endtask

  task automatic check_z_memory();
    for (int i = 0; i < z_chk_addr_q.size(); i++) begin
      assert (mem[z_chk_addr_q[i]] == z_chk_data_q[i])
        else report_mismatch("z memory", z_chk_data_q[i], mem[z_chk_addr_q[i]]);
    end
  endtask

  // Memory model and stream monitor sampling DUT outputs before the edge updates them
  always @(posedge clk_i) begin
    cycle_cnt++;
    assert (cycle_cnt <= cycle_limit) else report_failure("timeout, the streams did not finish");
    assert (i_dut.i_props.fail_cnt == 0) else report_failure("a protocol assertion fired");
    z_took  = z_stream.valid && z_ready;
    rd_pend = 1'b0;
    if (mem_req.req && mem_gnt) begin
      if (mem_req.wen) begin
        assert (z_addr_q.size() != 0) else report_failure("memory write with none expected");
        assert (mem_req.addr == z_addr_q[0])
          else report_mismatch("z address", z_addr_q[0], mem_req.addr);
        assert (mem_req.wdata == z_data_q[0])
          else report_mismatch("z data", z_data_q[0], mem_req.wdata);
        void'(z_addr_q.pop_front());
        void'(z_data_q.pop_front());
        mem[mem_req.addr] = mem_req.wdata;
      end else begin
        rd_pend = 1'b1;
        rd_data = mem[mem_req.addr];
      end
    end
    if (x_stream.valid && x_ready) begin
      assert (x_exp_q.size() != 0) else report_failure("X delivered a word with none expected");
      assert (x_stream.data == x_exp_q[0])
        else report_mismatch("x data", x_exp_q[0], x_stream.data);
      void'(x_exp_q.pop_front());
    end
    if (w_stream.valid && w_ready) begin
      assert (w_exp_q.size() != 0) else report_failure("W delivered a word with none expected");
      assert (w_stream.data == w_exp_q[0])
        else report_mismatch("w data", w_exp_q[0], w_stream.data);
      void'(w_exp_q.pop_front());
    end
  end

  // All three channels run when clear hits, Z writes above 16'h8000 and reads below it
  task automatic test_reset_clear();
    test_name = "reset_clear";
    next_cycle();
    check_idle("after reset");
    x_ctrl          = random_ctrl(14, 7);
    w_ctrl          = random_ctrl(14, 7);
    z_ctrl          = random_ctrl(14, 7);
    z_ctrl.base[15] = 1'b1;
    queue_reads(CHAN_X, x_ctrl);
    queue_reads(CHAN_W, w_ctrl);
    queue_writes(z_ctrl);
    repeat (6) next_cycle();
    clear_i = 1'b1;
    next_cycle();
    check_idle("after clear");
    x_exp_q.delete();
    w_exp_q.delete();
    z_src_q.delete();
    z_data_q.delete();
    z_addr_q.delete();
    z_stream = '0;
  endtask

  task automatic test_x_stream();
    test_name    = "x_stream";
    stretch_bits = 1;
    next_cycle();
    x_ctrl = random_ctrl(16, 16);
    queue_reads(CHAN_X, x_ctrl);
    wait_done(3'b100);
    check_drained();
  endtask

  task automatic test_x_w_shared();
    test_name = "x_w_shared";
    next_cycle();
    x_ctrl = random_ctrl(16, 16);
    w_ctrl = random_ctrl(16, 16);
    queue_reads(CHAN_X, x_ctrl);
    queue_reads(CHAN_W, w_ctrl);
    wait_done(3'b110);
    check_drained();
  endtask

  // Odd stride keeps all Z addresses of one stream distinct
  task automatic test_z_stream();
    test_name = "z_stream";
    next_cycle();
    z_ctrl           = random_ctrl(16, 16);
    z_ctrl.stride[0] = 1'b1;
    queue_writes(z_ctrl);
    wait_done(3'b001);
    check_drained();
    check_z_memory();
  endtask

  // Reads stay below 16'h8000 and writes above it, so Z never changes X or W data
  task automatic test_concurrent();
    test_name    = "concurrent";
    stretch_bits = 5;
    next_cycle();
    x_ctrl           = random_ctrl(14, 7);
    w_ctrl           = random_ctrl(14, 7);
    z_ctrl           = random_ctrl(14, 7);
    z_ctrl.base[15]  = 1'b1;
    z_ctrl.stride[0] = 1'b1;
    queue_reads(CHAN_X, x_ctrl);
    queue_reads(CHAN_W, w_ctrl);
    queue_writes(z_ctrl);
    wait_done(3'b111);
    check_drained();
    check_z_memory();
  endtask

  initial begin
    lfsr_q       = 32'h4038e104;
    rst_n_i      = 1'b0;
    clear_i      = 1'b0;
    x_ctrl       = '0;
    w_ctrl       = '0;
    z_ctrl       = '0;
    x_ready      = 1'b0;
    w_ready      = 1'b0;
    z_stream     = '0;
    mem_gnt      = 1'b0;
    mem_rsp      = '0;
    rd_pend      = 1'b0;
    rd_data      = '0;
    z_took       = 1'b0;
    x_hold       = 0;
    w_hold       = 0;
    stretch_bits = 1;
    cycle_cnt    = 0;
    cycle_limit  = RESET_CYCLES + 64;
    test_name    = "setup";
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = rand_bits(DATA_W);
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_clear();
    for (int r = 0; r < ROUNDS; r++) begin
      test_x_stream();
      test_x_w_shared();
      test_z_stream();
      test_concurrent();
    end
    if (i_dut.i_props.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Protocol assertions fired during the run");
    end
  end

endmodule

// File: files.f
rtl/streamer_pkg.sv
rtl/streamer_addr_gen.sv
rtl/streamer_source.sv
rtl/streamer_sink.sv
rtl/streamer_tcdm_mux.sv
rtl/streamer_top.sv
testbench/tb_streamer_properties.sv
testbench/tb_streamer.sv

// File: Bender.yml
package:
  name: streamer

sources:
  - rtl/streamer_pkg.sv
  - rtl/streamer_addr_gen.sv
  - rtl/streamer_source.sv
  - rtl/streamer_sink.sv
  - rtl/streamer_tcdm_mux.sv
  - rtl/streamer_top.sv
  - target: test
    files:
      - testbench/tb_streamer_properties.sv
      - testbench/tb_streamer.sv
